// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int DATA_WIDTH     = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int INST_WIDTH     = 32;
  localparam int IMM_WIDTH      = 16;
  localparam int SHAMT_WIDTH    = 5;

  // instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // values outside this list decode as a nop
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,
    OP_SLL  = 6'd7,
    OP_ADDI = 6'd8,
    OP_ORI  = 6'd9
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_SLL = 3'd6
  } alu_op_t;

  ////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////

  typedef struct packed {
    logic                   valid;
    logic                   reg_write;
    alu_op_t                alu_op;
    logic                   alu_src;
    reg_addr_t              rs;
    reg_addr_t              rt;
    reg_addr_t              dest;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [IMM_WIDTH-1:0]   immediate;
    word_t                  rs_data;
    word_t                  rt_data;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t dest;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire                clk,
  input  wire                reset,
  input  core_pkg::reg_addr_t rs_addr,
  input  core_pkg::reg_addr_t rt_addr,
  output core_pkg::word_t     rs_data,
  output core_pkg::word_t     rt_data,
  input  core_pkg::wb_t       wr
);

  core_pkg::word_t regs [core_pkg::NUM_REGS];

  // r0 reads zero and a same-cycle write bypasses the array
  function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
    core_pkg::word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wr.valid && wr.dest == addr) begin
      value = wr.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.dest != '0) begin
      regs[wr.dest] <= wr.data;
    end
  end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 inst_valid,
  input  core_pkg::word_t     inst,
  output core_pkg::reg_addr_t rs_addr,
  output core_pkg::reg_addr_t rt_addr,
  input  core_pkg::word_t     rs_data,
  input  core_pkg::word_t     rt_data,
  output core_pkg::id_ex_t    id_ex
);

  logic                             inst_valid_q;
  logic [core_pkg::INST_WIDTH-1:0]  inst_q;
  core_pkg::opcode_t                opcode;
  core_pkg::reg_addr_t              rd;
  core_pkg::reg_addr_t              dest;
  core_pkg::alu_op_t                alu_op;
  logic                             alu_src;
  logic                             reg_write;
  logic                             use_rt_dest;
  core_pkg::id_ex_t                 id_ex_next;

  // instruction captured at the strobe edge
  always_ff @(posedge clk) begin
    inst_q <= inst;
    if (reset) begin
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= inst_valid;
    end
  end

  ////////////////////////////////////////
  // fields
  ////////////////////////////////////////

  assign opcode  = core_pkg::opcode_t'(inst_q[core_pkg::OPCODE_MSB:core_pkg::OPCODE_LSB]);
  assign rs_addr = inst_q[core_pkg::RS_MSB:core_pkg::RS_LSB];
  assign rt_addr = inst_q[core_pkg::RT_MSB:core_pkg::RT_LSB];
  assign rd      = inst_q[core_pkg::RD_MSB:core_pkg::RD_LSB];

  // control decode
  always_comb begin
    alu_op      = core_pkg::ALU_ADD;
    alu_src     = 1'b0;
    reg_write   = 1'b1;
    use_rt_dest = 1'b0;
    case (opcode)
      core_pkg::OP_ADD:  alu_op = core_pkg::ALU_ADD;
      core_pkg::OP_SUB:  alu_op = core_pkg::ALU_SUB;
      core_pkg::OP_AND:  alu_op = core_pkg::ALU_AND;
      core_pkg::OP_OR:   alu_op = core_pkg::ALU_OR;
      core_pkg::OP_XOR:  alu_op = core_pkg::ALU_XOR;
      core_pkg::OP_SLT:  alu_op = core_pkg::ALU_SLT;
      core_pkg::OP_SLL:  alu_op = core_pkg::ALU_SLL;
      core_pkg::OP_ADDI: begin
        alu_op      = core_pkg::ALU_ADD;
        alu_src     = 1'b1;
        use_rt_dest = 1'b1;
      end
      core_pkg::OP_ORI: begin
        alu_op      = core_pkg::ALU_OR;
        alu_src     = 1'b1;
        use_rt_dest = 1'b1;
      end
      // nop and unknown opcodes
      default: reg_write = 1'b0;
    endcase
  end

  // immediates write rt, r-type writes rd
  assign dest = use_rt_dest ? rt_addr : rd;

  always_comb begin
    id_ex_next.valid     = inst_valid_q;
    id_ex_next.reg_write = reg_write && (dest != '0);
    id_ex_next.alu_op    = alu_op;
    id_ex_next.alu_src   = alu_src;
    id_ex_next.rs        = rs_addr;
    id_ex_next.rt        = rt_addr;
    id_ex_next.dest      = dest;
    id_ex_next.shamt     = inst_q[core_pkg::SHAMT_MSB:core_pkg::SHAMT_LSB];
    id_ex_next.immediate = inst_q[core_pkg::IMM_MSB:core_pkg::IMM_LSB];
    id_ex_next.rs_data   = rs_data;
    id_ex_next.rt_data   = rt_data;
  end

  always_ff @(posedge clk) begin
    id_ex <= id_ex_next;
    if (reset) begin
      id_ex.valid     <= 1'b0;
      id_ex.reg_write <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  core_pkg::alu_op_t             alu_op,
  input  core_pkg::word_t               a,
  input  core_pkg::word_t               b,
  input  logic [core_pkg::SHAMT_WIDTH-1:0] shamt,
  output core_pkg::word_t               result
);

  logic less;

  assign less = $signed(a) < $signed(b);

  ////////////////////////////////////////
  // function select
  ////////////////////////////////////////

  always_comb begin
    case (alu_op)
      core_pkg::ALU_ADD: begin
        result = a + b;
      end
      core_pkg::ALU_SUB: begin
        result = a - b;
      end
      core_pkg::ALU_AND: begin
        result = a & b;
      end
      core_pkg::ALU_OR: begin
        result = a | b;
      end
      core_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      // signed compare, result is 0 or 1
      core_pkg::ALU_SLT: begin
        result = {{(core_pkg::DATA_WIDTH-1){1'b0}}, less};
      end
      // shift source is rt, not rs
      core_pkg::ALU_SLL: begin
        result = b << shamt;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  wire              clk,
  input  wire              reset,
  input  core_pkg::id_ex_t id_ex,
  output core_pkg::wb_t    wb
);

  logic            fwd_a;
  logic            fwd_b;
  core_pkg::word_t op_a;
  core_pkg::word_t op_rt;
  core_pkg::word_t op_b;
  core_pkg::word_t imm_ext;
  core_pkg::word_t alu_result;
  core_pkg::wb_t   wb_next;

  ////////////////////////////////////////
  // forwarding from write-back
  ////////////////////////////////////////

  // older results are already in the register file
  assign fwd_a = wb.valid && (wb.dest == id_ex.rs) && (id_ex.rs != '0);
  assign fwd_b = wb.valid && (wb.dest == id_ex.rt) && (id_ex.rt != '0);

  assign op_a  = fwd_a ? wb.data : id_ex.rs_data;
  assign op_rt = fwd_b ? wb.data : id_ex.rt_data;

  // immediate is zero extended
  assign imm_ext = {{(core_pkg::DATA_WIDTH-core_pkg::IMM_WIDTH){1'b0}}, id_ex.immediate};
  assign op_b    = id_ex.alu_src ? imm_ext : op_rt;

  alu u_alu (
    .alu_op (id_ex.alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (id_ex.shamt),
    .result (alu_result)
  );

  ////////////////////////////////////////
  // write-back register
  ////////////////////////////////////////

  always_comb begin
    wb_next.valid = id_ex.valid && id_ex.reg_write;
    wb_next.dest  = id_ex.dest;
    wb_next.data  = alu_result;
  end

  always_ff @(posedge clk) begin
    wb <= wb_next;
    if (reset) begin
      wb.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/pipeline_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_core (
  input  wire             clk,
  input  wire             reset,
  input  logic            inst_valid,
  input  core_pkg::word_t inst,
  output core_pkg::wb_t   wb
);

  core_pkg::reg_addr_t rs_addr;
  core_pkg::reg_addr_t rt_addr;
  core_pkg::word_t     rs_data;
  core_pkg::word_t     rt_data;
  core_pkg::id_ex_t    id_ex;

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .id_ex      (id_ex)
  );

  // written from the write-back result
  register_file u_regfile (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr      (wb)
  );

  execute_stage u_execute (
    .clk   (clk),
    .reset (reset),
    .id_ex (id_ex),
    .wb    (wb)
  );

endmodule

`default_nettype wire

// ==== verification/core_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_checker (
  input  wire             clk,
  input  wire             reset,
  input  logic            inst_valid,
  input  core_pkg::word_t inst,
  input  core_pkg::wb_t   wb,
  output int              pass_count,
  output int              fail_count,
  output logic            idle
);

  typedef struct packed {
    logic                write;
    core_pkg::reg_addr_t dest;
    core_pkg::word_t     data;
  } result_t;

  typedef struct packed {
    int                  due_edge;
    core_pkg::reg_addr_t dest;
    core_pkg::word_t     data;
  } pending_t;

  core_pkg::word_t model [core_pkg::NUM_REGS];
  pending_t        expected_q [$];
  pending_t        entry;
  pending_t        head;
  result_t         expected;
  int              edge_count;
  int              last_issue;
  logic            in_reset;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic result_t reference_result(input core_pkg::word_t instr,
                                               input core_pkg::word_t regs [core_pkg::NUM_REGS]);
    result_t         res;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t imm;
    logic [4:0]      shamt;
    // r0 is never written in the model
    a     = regs[instr[core_pkg::RS_MSB:core_pkg::RS_LSB]];
    b     = regs[instr[core_pkg::RT_MSB:core_pkg::RT_LSB]];
    imm   = {16'h0000, instr[core_pkg::IMM_MSB:core_pkg::IMM_LSB]};
    shamt = instr[core_pkg::SHAMT_MSB:core_pkg::SHAMT_LSB];
    res.write = 1'b1;
    res.dest  = instr[core_pkg::RD_MSB:core_pkg::RD_LSB];
    res.data  = '0;
    case (instr[core_pkg::OPCODE_MSB:core_pkg::OPCODE_LSB])
      core_pkg::OP_ADD: res.data = a + b;
      core_pkg::OP_SUB: res.data = a - b;
      core_pkg::OP_AND: res.data = a & b;
      core_pkg::OP_OR:  res.data = a | b;
      core_pkg::OP_XOR: res.data = a ^ b;
      core_pkg::OP_SLT: res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      core_pkg::OP_SLL: res.data = b << shamt;
      // immediate forms write rt
      core_pkg::OP_ADDI: begin
        res.dest = instr[core_pkg::RT_MSB:core_pkg::RT_LSB];
        res.data = a + imm;
      end
      core_pkg::OP_ORI: begin
        res.dest = instr[core_pkg::RT_MSB:core_pkg::RT_LSB];
        res.data = a | imm;
      end
      default: res.write = 1'b0;
    endcase
    if (res.dest == '0) begin
      res.write = 1'b0;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // issue tracking and compare
  ////////////////////////////////////////

  initial begin
    pass_count = 0;
    fail_count = 0;
    idle       = 1'b1;
    edge_count = 0;
    last_issue = -8;
    in_reset   = 1'b1;
    forever begin
      // inputs are stable at the rising edge
      @(posedge clk);
      in_reset = reset;
      if (reset) begin
        for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
          model[i] = '0;
        end
        expected_q.delete();
      end else begin
        edge_count = edge_count + 1;
        if (inst_valid) begin
          expected   = reference_result(inst, model);
          last_issue = edge_count;
          if (expected.write) begin
            model[expected.dest] = expected.data;
            entry.due_edge = edge_count + 2;
            entry.dest     = expected.dest;
            entry.data     = expected.data;
            expected_q.push_back(entry);
          end
        end
      end
      // wb is stable at the falling edge
      @(negedge clk);
      if (!in_reset) begin
        if (wb.valid !== 1'b0) begin
          if (expected_q.size() == 0 || expected_q[0].due_edge != edge_count) begin
            $display("unexpected write-back of 0x%08h to r%0d at %0t ns, nothing was due",
                     wb.data, wb.dest, $time);
            fail_count = fail_count + 1;
          end else begin
            head = expected_q.pop_front();
            if (wb.dest !== head.dest || wb.data !== head.data) begin
              $display("mismatch at %0t ns: expected r%0d = 0x%08h, got r%0d = 0x%08h",
                       $time, head.dest, head.data, wb.dest, wb.data);
              fail_count = fail_count + 1;
            end else begin
              pass_count = pass_count + 1;
            end
          end
        end else if (expected_q.size() != 0 && expected_q[0].due_edge <= edge_count) begin
          head = expected_q.pop_front();
          $display("missing write-back: r%0d should have received 0x%08h by %0t ns",
                   head.dest, head.data, $time);
          fail_count = fail_count + 1;
        end
      end
      idle = (expected_q.size() == 0) && (edge_count >= last_issue + 2);
    end
  end

endmodule

`default_nettype wire

// ==== verification/core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_tb;

  localparam int DRAIN_LIMIT  = 64;
  localparam int RANDOM_COUNT = 2000;

  logic            clk;
  logic            reset;
  logic            inst_valid;
  core_pkg::word_t inst;
  core_pkg::wb_t   wb;
  int              pass_count;
  int              fail_count;
  logic            idle;
  logic            timed_out;

  pipeline_core u_dut (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (wb)
  );

  core_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (wb),
    .pass_count (pass_count),
    .fail_count (fail_count),
    .idle       (idle)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // encoding and drive helpers
  ////////////////////////////////////////

  function automatic core_pkg::word_t make_rtype(input logic [5:0] op,
      input core_pkg::reg_addr_t rs, input core_pkg::reg_addr_t rt,
      input core_pkg::reg_addr_t rd, input logic [4:0] shamt);
    return {op, rs, rt, rd, shamt, 6'b000000};
  endfunction

  function automatic core_pkg::word_t make_itype(input logic [5:0] op,
      input core_pkg::reg_addr_t rs, input core_pkg::reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic issue(input core_pkg::word_t instr);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = instr;
  endtask

  // invalid cycles carry junk on inst
  task automatic bubbles(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      inst_valid = 1'b0;
      inst       = $urandom();
    end
  endtask

  task automatic issue_alone(input core_pkg::word_t instr);
    issue(instr);
    bubbles(3);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    bubbles(1);
    @(posedge clk);
    while (!idle && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited = waited + 1;
    end
    if (!idle) begin
      $display("timeout: pipeline did not drain within %0d cycles", DRAIN_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "isolated operations";
      3:       return "back-to-back dependence";
      4:       return "distance-two dependence";
      5:       return "silent instructions";
      default: return "random stream";
    endcase
  endfunction

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reset_test();
    bubbles(6);
    issue(make_rtype(core_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
  endtask

  task automatic isolated_ops_test();
    issue_alone(make_itype(core_pkg::OP_ADDI, 5'd0, 5'd1, 16'h1234));
    issue_alone(make_itype(core_pkg::OP_ORI, 5'd0, 5'd2, 16'hf0f0));
    issue_alone(make_rtype(core_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_SUB, 5'd0, 5'd1, 5'd4, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_AND, 5'd1, 5'd2, 5'd5, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_OR, 5'd1, 5'd2, 5'd6, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_XOR, 5'd1, 5'd2, 5'd7, 5'd0));
    // negative against positive, both ways
    issue_alone(make_rtype(core_pkg::OP_SLT, 5'd4, 5'd1, 5'd8, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_SLT, 5'd1, 5'd4, 5'd9, 5'd0));
    issue_alone(make_rtype(core_pkg::OP_SLL, 5'd0, 5'd2, 5'd10, 5'd7));
    issue_alone(make_itype(core_pkg::OP_ORI, 5'd4, 5'd11, 16'h00ff));
  endtask

  task automatic back_to_back_test();
    issue(make_itype(core_pkg::OP_ADDI, 5'd0, 5'd12, 16'd5));
    issue(make_rtype(core_pkg::OP_ADD, 5'd12, 5'd12, 5'd13, 5'd0));
    issue(make_rtype(core_pkg::OP_SLL, 5'd0, 5'd13, 5'd14, 5'd3));
    issue(make_rtype(core_pkg::OP_SUB, 5'd14, 5'd12, 5'd15, 5'd0));
    issue(make_rtype(core_pkg::OP_XOR, 5'd15, 5'd13, 5'd16, 5'd0));
    issue(make_itype(core_pkg::OP_ORI, 5'd16, 5'd17, 16'h8000));
    issue(make_rtype(core_pkg::OP_SLT, 5'd17, 5'd16, 5'd18, 5'd0));
  endtask

  task automatic distance_two_test();
    issue(make_itype(core_pkg::OP_ADDI, 5'd0, 5'd20, 16'h0077));
    issue(make_itype(core_pkg::OP_ADDI, 5'd0, 5'd21, 16'h0003));
    issue(make_rtype(core_pkg::OP_ADD, 5'd20, 5'd20, 5'd22, 5'd0));
    issue(make_rtype(core_pkg::OP_XOR, 5'd21, 5'd0, 5'd23, 5'd0));
    issue(make_itype(core_pkg::OP_ADDI, 5'd0, 5'd20, 16'h0099));
    bubbles(1);
    issue(make_rtype(core_pkg::OP_SUB, 5'd20, 5'd21, 5'd25, 5'd0));
  endtask

  task automatic silent_test();
    issue(32'h0000_0000);
    issue({6'd63, 26'h3ff_ffff});
    issue(make_rtype(6'd10, 5'd1, 5'd2, 5'd26, 5'd0));
    issue(make_rtype(core_pkg::OP_ADD, 5'd1, 5'd2, 5'd0, 5'd0));
    issue(make_itype(core_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0055));
    // r0 must still read zero
    issue(make_rtype(core_pkg::OP_OR, 5'd0, 5'd0, 5'd26, 5'd0));
    issue(make_rtype(core_pkg::OP_ADD, 5'd0, 5'd3, 5'd27, 5'd0));
  endtask

  // registers 0 to 7 only, opcodes 10 and 11 are unknown
  task automatic random_test();
    core_pkg::word_t instr;
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      instr = {6'($urandom_range(0, 11)), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
               5'($urandom_range(0, 7)), 11'($urandom())};
      issue(instr);
      if ($urandom_range(0, 3) == 0) begin
        bubbles(int'($urandom_range(1, 3)));
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int pass_start;
    int fail_start;
    void'($urandom(7583));
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    timed_out  = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    for (int id = 1; id <= 6; id++) begin
      if (!timed_out) begin
        pass_start = pass_count;
        fail_start = fail_count;
        case (id)
          1:       reset_test();
          2:       isolated_ops_test();
          3:       back_to_back_test();
          4:       distance_two_test();
          5:       silent_test();
          default: random_test();
        endcase
        drain();
        $display("test %0d %s: %0d checks passed, %0d failed", id, test_name(id),
                 pass_count - pass_start, fail_count - fail_start);
      end
    end
    $display("total: %0d checks passed, %0d checks failed", pass_count, fail_count);
    if (timed_out || fail_count != 0 || pass_count == 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pipeline_core.f ====
design/core_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/pipeline_core.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_tb -f pipeline_core.f -o core_tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
